// File: compile.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/Controller.sv
rtl/FetchUnit.sv
rtl/RegisterFile.sv
rtl/Alu.sv
rtl/DataMemory.sv
rtl/MipsCore.sv
tb/tbMipsCore.sv

// File: Makefile
# Verilator build and run for the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= tbMipsCore
LOG       ?= sim.log
SEED      ?= 35939
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "All tests passed!" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tbMipsCore.sv
`timescale 1ns/1ns
`include "mips_settings.svh"

module tbMipsCore #(
    parameter int unsigned SEED = 32'h8c63
);
    import mipsPkg::*;

    localparam int RunTimeout     = 200;
    localparam int DrainCycles    = 8;
    localparam int ModelStepLimit = 256;

    // Opcodes and funct codes straight from the ISA
    localparam logic [5:0] opcRtype = 6'b000000;
    localparam logic [5:0] opcJ     = 6'b000010;
    localparam logic [5:0] opcBne   = 6'b000101;
    localparam logic [5:0] opcAddi  = 6'b001000;
    localparam logic [5:0] opcOri   = 6'b001101;
    localparam logic [5:0] opcMul   = 6'b011100;
    localparam logic [5:0] opcLw    = 6'b100011;
    localparam logic [5:0] fnAdd    = 6'b100000;
    localparam logic [5:0] fnSub    = 6'b100010;
    localparam logic [5:0] fnSlt    = 6'b101010;
    localparam logic [5:0] fnMul    = 6'b000010;

    logic      clk;
    logic      rstN;
    logic      run;
    logic      imemWe;
    imemAddr_t imemAddr;
    word_t     imemWdata;
    logic      dmemWe;
    dmemAddr_t dmemAddr;
    word_t     dmemWdata;
    word_t     dmemRdata;
    retire_t   retire;

    int     errors;
    int     checks;
    int     timeouts;
    integer seed;

    // Program under test and the model's view of the machine
    word_t    prog [$];
    word_t    progImage [`MIPS_IMEM_DEPTH];
    word_t    modelRegs [`MIPS_REG_COUNT];
    word_t    modelDmem [`MIPS_DMEM_DEPTH];
    regAddr_t expRd [$];
    word_t    expData [$];
    regAddr_t gotRd [$];
    word_t    gotData [$];

    MipsCore u_MipsCore (
        .clk       (clk),
        .rstN      (rstN),
        .run       (run),
        .imemWe    (imemWe),
        .imemAddr  (imemAddr),
        .imemWdata (imemWdata),
        .dmemWe    (dmemWe),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemRdata (dmemRdata),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Encoding
    ////////////////////////////////////////////////////////////

    function automatic word_t rType(input logic [5:0] op, input regAddr_t rd,
                                    input regAddr_t rs, input regAddr_t rt,
                                    input logic [5:0] funct);
        return {op, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input regAddr_t rt,
                                    input regAddr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(input logic [25:0] target);
        return {opcJ, target};
    endfunction

    ////////////////////////////////////////////////////////////
    // Host side helpers
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Whole imem is written and unused words get an address-tagged bad opcode
    task automatic loadProgram();
        word_t w;
        for (int i = 0; i < `MIPS_IMEM_DEPTH; i++) begin
            w = (i < prog.size()) ? prog[i] : {6'b111111, 20'd0, imemAddr_t'(i)};
            progImage[i] = w;
            @(negedge clk);
            imemWe    = 1'b1;
            imemAddr  = imemAddr_t'(i);
            imemWdata = w;
        end
        @(negedge clk);
        imemWe = 1'b0;
    endtask

    task automatic writeDmem(input dmemAddr_t addr, input word_t data);
        @(negedge clk);
        dmemWe    = 1'b1;
        dmemAddr  = addr;
        dmemWdata = data;
        modelDmem[addr] = data;
        @(negedge clk);
        dmemWe = 1'b0;
    endtask

    task automatic readBackDmem(input dmemAddr_t addr, input word_t exp);
        @(negedge clk);
        dmemAddr = addr;
        @(negedge clk);
        checkValue($sformatf("dmemRdata[%0d]", addr), dmemRdata, exp);
    endtask

    task automatic collectRetire();
        if (retire.valid === 1'b1) begin
            gotRd.push_back(retire.rd);
            gotData.push_back(retire.data);
        end
    endtask

    // Run until count write-backs then drain and halt
    task automatic runUntil(input int count);
        int cycles;
        gotRd   = {};
        gotData = {};
        @(negedge clk);
        run    = 1'b1;
        cycles = 0;
        while (gotRd.size() < count && cycles < RunTimeout) begin
            @(negedge clk);
            collectRetire();
            cycles++;
        end
        if (gotRd.size() < count) begin
            timeouts++;
            $display("Timeout: only %0d of %0d write-backs seen after %0d cycles",
                     gotRd.size(), count, cycles);
        end
        // Late or extra write-backs still get recorded
        repeat (DrainCycles) begin
            @(negedge clk);
            collectRetire();
        end
        run = 1'b0;
        repeat (3) begin
            @(negedge clk);
            collectRetire();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Instruction model
    ////////////////////////////////////////////////////////////

    // Sequential ISA walk where a taken redirect simply skips ahead
    task automatic modelProgram();
        imemAddr_t  pc;
        imemAddr_t  nextPc;
        word_t      instr;
        logic [5:0] op;
        regAddr_t   dest;
        word_t      a;
        word_t      b;
        word_t      simm;
        word_t      addr;
        word_t      result;
        longint     prod;
        logic       write;
        logic       done;
        int         steps;
        expRd   = {};
        expData = {};
        pc      = '0;
        done    = 1'b0;
        steps   = 0;
        while (!done && steps < ModelStepLimit) begin
            instr  = progImage[pc];
            op     = instr[31:26];
            a      = modelRegs[instr[25:21]];
            b      = modelRegs[instr[20:16]];
            simm   = {{16{instr[15]}}, instr[15:0]};
            dest   = instr[20:16];
            result = '0;
            write  = 1'b0;
            nextPc = pc + imemAddr_t'(1);
            case (op)
                opcRtype: begin
                    dest  = instr[15:11];
                    write = 1'b1;
                    case (instr[5:0])
                        fnAdd:   result = a + b;
                        fnSub:   result = a - b;
                        fnSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: write = 1'b0;
                    endcase
                end
                opcMul: begin
                    dest   = instr[15:11];
                    write  = 1'b1;
                    prod   = longint'($signed(a)) * longint'($signed(b));
                    result = prod[31:0];
                end
                opcLw: begin
                    // Word index from bits 7..2 of the byte address
                    addr   = a + simm;
                    result = modelDmem[addr[7:2]];
                    write  = 1'b1;
                end
                opcAddi: begin
                    result = a + simm;
                    write  = 1'b1;
                end
                opcOri: begin
                    result = a | {16'd0, instr[15:0]};
                    write  = 1'b1;
                end
                opcBne: begin
                    if (a != b) begin
                        nextPc = pc + imemAddr_t'(1) + imemAddr_t'(simm[5:0]);
                    end
                end
                opcJ: begin
                    nextPc = instr[5:0];
                    // Jump to itself ends the program
                    done   = (nextPc == pc);
                end
                default: begin
                end
            endcase
            if (write) begin
                expRd.push_back(dest);
                expData.push_back(result);
                if (dest != '0) begin
                    modelRegs[dest] = result;
                end
            end
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic compareRetires(input string tag);
        checkValue($sformatf("%s retire count", tag), gotRd.size(), expRd.size());
        for (int i = 0; i < gotRd.size() && i < expRd.size(); i++) begin
            checkValue($sformatf("%s retire.rd #%0d", tag, i),
                       word_t'(gotRd[i]), word_t'(expRd[i]));
            checkValue($sformatf("%s retire.data #%0d", tag, i), gotData[i], expData[i]);
        end
    endtask

    task automatic runProgram(input string tag);
        loadProgram();
        modelProgram();
        runUntil(expRd.size());
        compareRetires(tag);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic aluOps();
        // Idle core writes nothing back
        repeat (10) begin
            @(negedge clk);
            checkValue("retire.valid idle", word_t'(retire.valid), 32'd0);
        end
        prog = {};
        prog.push_back(iType(opcAddi, 5'd1, 5'd0, 16'd25));
        prog.push_back(iType(opcAddi, 5'd2, 5'd0, 16'hfff9));
        prog.push_back(rType(opcRtype, 5'd3, 5'd1, 5'd2, fnAdd));
        prog.push_back(rType(opcRtype, 5'd4, 5'd2, 5'd1, fnSub));
        prog.push_back(rType(opcRtype, 5'd5, 5'd2, 5'd1, fnSlt));
        prog.push_back(rType(opcRtype, 5'd6, 5'd1, 5'd2, fnSlt));
        prog.push_back(rType(opcRtype, 5'd7, 5'd0, 5'd1, fnSub));
        prog.push_back(jType(26'd7));
        runProgram("aluOps");
    endtask

    task automatic immediateExtension();
        word_t       rnd;
        logic [15:0] immNeg;
        logic [15:0] immOri;
        logic [15:0] immZero;
        rnd     = $random(seed);
        immNeg  = rnd[15:0] | 16'h8000;
        rnd     = $random(seed);
        immOri  = rnd[15:0] | 16'h8000;
        rnd     = $random(seed);
        immZero = rnd[15:0] | 16'h0001;
        prog = {};
        prog.push_back(iType(opcAddi, 5'd8, 5'd0, immNeg));
        prog.push_back(iType(opcOri, 5'd9, 5'd0, immOri));
        prog.push_back(iType(opcAddi, 5'd0, 5'd0, immZero));
        // r0 must still read as zero
        prog.push_back(rType(opcRtype, 5'd10, 5'd0, 5'd0, fnAdd));
        prog.push_back(rType(opcRtype, 5'd11, 5'd0, 5'd9, fnAdd));
        prog.push_back(jType(26'd5));
        runProgram("immediates");
        if (gotData.size() >= 4) begin
            checkValue("retire.data addi sext", gotData[0], {16'hffff, immNeg});
            checkValue("retire.data ori zext", gotData[1], {16'h0000, immOri});
            checkValue("retire.rd r0 write", word_t'(gotRd[2]), 32'd0);
            checkValue("retire.data r0 read", gotData[3], 32'd0);
        end
    endtask

    task automatic signedMultiply();
        word_t  opA;
        word_t  opB;
        longint prod;
        opA = $random(seed);
        opB = $random(seed);
        // Second factor negative
        opB = opB | 32'h8000_0000;
        writeDmem(dmemAddr_t'(10), opA);
        writeDmem(dmemAddr_t'(11), opB);
        prog = {};
        prog.push_back(iType(opcLw, 5'd12, 5'd0, 16'd40));
        prog.push_back(iType(opcLw, 5'd13, 5'd0, 16'd44));
        prog.push_back(rType(opcMul, 5'd14, 5'd12, 5'd13, fnMul));
        prog.push_back(rType(opcMul, 5'd15, 5'd13, 5'd13, fnMul));
        prog.push_back(jType(26'd4));
        runProgram("mul");
        prod = longint'($signed(opA)) * longint'($signed(opB));
        if (gotData.size() >= 3) begin
            checkValue("retire.data mul", gotData[2], prod[31:0]);
        end
    endtask

    task automatic loadWords();
        word_t vals [5];
        word_t rnd;
        for (int i = 0; i < 5; i++) begin
            rnd     = $random(seed);
            vals[i] = rnd;
            writeDmem(dmemAddr_t'(19 + i), vals[i]);
        end
        for (int i = 0; i < 5; i++) begin
            readBackDmem(dmemAddr_t'(19 + i), vals[i]);
        end
        // Base register points at word 20
        prog = {};
        prog.push_back(iType(opcAddi, 5'd16, 5'd0, 16'd80));
        prog.push_back(iType(opcLw, 5'd17, 5'd16, 16'd0));
        prog.push_back(iType(opcLw, 5'd18, 5'd16, 16'd4));
        prog.push_back(iType(opcLw, 5'd19, 5'd16, 16'd12));
        prog.push_back(iType(opcLw, 5'd20, 5'd16, 16'hfffc));
        prog.push_back(jType(26'd5));
        runProgram("loads");
        if (gotData.size() >= 5) begin
            checkValue("retire.data lw +0", gotData[1], vals[1]);
            checkValue("retire.data lw -4", gotData[4], vals[0]);
        end
    endtask

    task automatic branchAndJump();
        prog = {};
        prog.push_back(iType(opcAddi, 5'd1, 5'd0, 16'd3));
        prog.push_back(iType(opcAddi, 5'd2, 5'd0, 16'd3));
        // Equal operands fall through
        prog.push_back(iType(opcBne, 5'd2, 5'd1, 16'd2));
        prog.push_back(iType(opcAddi, 5'd21, 5'd0, 16'd1));
        // Taken to word 7
        prog.push_back(iType(opcBne, 5'd21, 5'd1, 16'd2));
        prog.push_back(iType(opcAddi, 5'd22, 5'd0, 16'd2));
        prog.push_back(iType(opcAddi, 5'd22, 5'd0, 16'd3));
        prog.push_back(iType(opcAddi, 5'd23, 5'd0, 16'd4));
        prog.push_back(jType(26'd11));
        prog.push_back(iType(opcAddi, 5'd24, 5'd0, 16'd5));
        prog.push_back(iType(opcAddi, 5'd24, 5'd0, 16'd6));
        prog.push_back(iType(opcAddi, 5'd25, 5'd0, 16'd7));
        prog.push_back(jType(26'd12));
        runProgram("branches");
        foreach (gotRd[i]) begin
            if (gotRd[i] == 5'd22 || gotRd[i] == 5'd24) begin
                errors++;
                $display("Squashed or skipped instruction wrote back to r%0d", gotRd[i]);
            end
        end
    endtask

    task automatic unknownAndRestart();
        prog = {};
        prog.push_back(iType(opcAddi, 5'd26, 5'd0, 16'd11));
        prog.push_back({6'b111111, 26'h0000123});
        prog.push_back(iType(opcAddi, 5'd27, 5'd26, 16'd5));
        prog.push_back({6'b110000, 26'h3ff0000});
        prog.push_back(rType(opcRtype, 5'd28, 5'd26, 5'd27, fnAdd));
        prog.push_back(jType(26'd5));
        runProgram("unknown");
        // Second run from word 0 without reloading
        // Same expected sequence as the first run
        runUntil(expRd.size());
        compareRetires("restart");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        seed      = SEED;
        rstN      = 1'b0;
        run       = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemWdata = '0;
        dmemWe    = 1'b0;
        dmemAddr  = '0;
        dmemWdata = '0;
        for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            modelDmem[i] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        aluOps();
        immediateExtension();
        signedMultiply();
        loadWords();
        branchAndJump();
        unknownAndRestart();

        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: rtl/MipsCore.sv
`timescale 1ns/1ns
`include "mips_settings.svh"

module MipsCore (
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    input  logic               imemWe,
    input  mipsPkg::imemAddr_t imemAddr,
    input  mipsPkg::word_t     imemWdata,
    input  logic               dmemWe,
    input  mipsPkg::dmemAddr_t dmemAddr,
    input  mipsPkg::word_t     dmemWdata,
    output mipsPkg::word_t     dmemRdata,
    output mipsPkg::retire_t   retire
);
    import mipsPkg::*;

    word_t     fetchInstr;
    imemAddr_t fetchPc;
    logic      fetchValid;
    logic      squash;
    logic      controlEnable;
    logic      redirect;
    imemAddr_t redirectPc;
    ctrl_t     ctrl;
    logic      branchDiffer;
    logic      isOri;
    regAddr_t  wrAddr;
    word_t     rsData;
    word_t     rtData;
    word_t     immExt;
    word_t     aluB;
    word_t     aluResult;
    dmemAddr_t loadAddr;
    word_t     loadData;
    word_t     wbData;

    ////////////////////////////////////////////////////////////
    // Fetch stage
    ////////////////////////////////////////////////////////////

    FetchUnit u_FetchUnit (
        .clk        (clk),
        .rstN       (rstN),
        .run        (run),
        .imemWe     (imemWe),
        .imemAddr   (imemAddr),
        .imemWdata  (imemWdata),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetchInstr (fetchInstr),
        .fetchPc    (fetchPc),
        .fetchValid (fetchValid)
    );

    // Slot behind a taken redirect is dropped
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            squash <= 1'b0;
        end else begin
            squash <= run && redirect;
        end
    end

    assign controlEnable = fetchValid && !squash;

    ////////////////////////////////////////////////////////////
    // Execute stage
    ////////////////////////////////////////////////////////////

    Controller u_Controller (
        .instruction   (fetchInstr),
        .branchDiffer  (branchDiffer),
        .controlEnable (controlEnable),
        .ctrl          (ctrl)
    );

    RegisterFile u_RegisterFile (
        .clk    (clk),
        .rstN   (rstN),
        .rs     (fetchInstr[25:21]),
        .rt     (fetchInstr[20:16]),
        .we     (ctrl.regWrite),
        .rd     (wrAddr),
        .wdata  (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    // ori zero-extends, everything else sign-extends
    assign isOri  = (opcode_t'(fetchInstr[31:26]) == OpOri);
    assign immExt = isOri ? word_t'(fetchInstr[15:0])
                          : {{(`MIPS_WORD_W-16){fetchInstr[15]}}, fetchInstr[15:0]};

    // Operand and destination select
    assign aluB   = ctrl.aluSrc ? immExt : rtData;
    assign wrAddr = ctrl.regDst ? fetchInstr[15:11] : fetchInstr[20:16];

    // bne compare
    assign branchDiffer = (rsData != rtData);

    // Branch target in words, jump takes the low target bits
    assign redirect   = ctrl.pcSrc || ctrl.jump;
    assign redirectPc = ctrl.jump ? imemAddr_t'(fetchInstr[25:0])
                                  : fetchPc + imemAddr_t'(1) + imemAddr_t'(immExt);

    Alu u_Alu (
        .aluControl (ctrl.aluControl),
        .a          (rsData),
        .b          (aluB),
        .result     (aluResult)
    );

    // Byte address to word index, parked at 0 when not loading
    assign loadAddr = ctrl.memRead ? dmemAddr_t'(aluResult >> 2) : '0;

    DataMemory u_DataMemory (
        .clk       (clk),
        .readAddr  (loadAddr),
        .readData  (loadData),
        .hostWe    (dmemWe),
        .hostAddr  (dmemAddr),
        .hostWdata (dmemWdata),
        .hostRdata (dmemRdata)
    );

    assign wbData = ctrl.memToReg ? loadData : aluResult;

    ////////////////////////////////////////////////////////////
    // Retire port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= ctrl.regWrite;
            retire.rd    <= wrAddr;
            retire.data  <= wbData;
        end
    end

    // Exactly one dead slot follows a taken redirect
    assert property (@(posedge clk) disable iff (!rstN)
        redirect |=> !(ctrl.regWrite || redirect))
        else $error("slot after redirect was not squashed");

endmodule

// File: rtl/DataMemory.sv
`timescale 1ns/1ns
`include "mips_settings.svh"

module DataMemory (
    input  logic               clk,
    input  mipsPkg::dmemAddr_t readAddr,
    output mipsPkg::word_t     readData,
    input  logic               hostWe,
    input  mipsPkg::dmemAddr_t hostAddr,
    input  mipsPkg::word_t     hostWdata,
    output mipsPkg::word_t     hostRdata
);
    import mipsPkg::*;

    word_t mem [`MIPS_DMEM_DEPTH];

    // Host preload, takes effect at the edge
    always_ff @(posedge clk) begin
        if (hostWe) begin
            mem[hostAddr] <= hostWdata;
        end
    end

    // Core load port
    assign readData = mem[readAddr];

    // Host readback
    assign hostRdata = mem[hostAddr];

endmodule

// File: rtl/Alu.sv
`timescale 1ns/1ns

module Alu (
    input  mipsPkg::aluCtrl_t aluControl,
    input  mipsPkg::word_t    a,
    input  mipsPkg::word_t    b,
    output mipsPkg::word_t    result
);
    import mipsPkg::*;

    always_comb begin
        case (aluControl)
            AluAdd: begin
                result = a + b;
            end
            AluSub: begin
                result = a - b;
            end
            AluMul: begin
                // Low half of the signed product
                result = word_t'($signed(a) * $signed(b));
            end
            AluOr: begin
                result = a | b;
            end
            AluSlt: begin
                // Signed compare, 1 or 0
                result = word_t'($signed(a) < $signed(b));
            end
            default: begin
                // None, off and unused codes
                result = '0;
            end
        endcase
    end

endmodule

// File: rtl/RegisterFile.sv
`timescale 1ns/1ns
`include "mips_settings.svh"

module RegisterFile (
    input  logic              clk,
    input  logic              rstN,
    input  mipsPkg::regAddr_t rs,
    input  mipsPkg::regAddr_t rt,
    input  logic              we,
    input  mipsPkg::regAddr_t rd,
    input  mipsPkg::word_t    wdata,
    output mipsPkg::word_t    rsData,
    output mipsPkg::word_t    rtData
);
    import mipsPkg::*;

    word_t regs [`MIPS_REG_COUNT];

    // Write port, r0 never written
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Read ports, old value during the write cycle
    assign rsData = (rs == '0) ? '0 : regs[rs];
    assign rtData = (rt == '0) ? '0 : regs[rt];

endmodule

// File: rtl/FetchUnit.sv
`timescale 1ns/1ns
`include "mips_settings.svh"

module FetchUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    input  logic               imemWe,
    input  mipsPkg::imemAddr_t imemAddr,
    input  mipsPkg::word_t     imemWdata,
    input  logic               redirect,
    input  mipsPkg::imemAddr_t redirectPc,
    output mipsPkg::word_t     fetchInstr,
    output mipsPkg::imemAddr_t fetchPc,
    output logic               fetchValid
);
    import mipsPkg::*;

    // Instruction store, host writable
    word_t     imem [`MIPS_IMEM_DEPTH];
    imemAddr_t pc;
    imemAddr_t nextPc;

    // Redirect wins over sequential fetch
    assign nextPc = redirect ? redirectPc : pc + imemAddr_t'(1);

    ////////////////////////////////////////////////////////////
    // PC and valid flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc         <= '0;
            fetchValid <= 1'b0;
        end else if (!run) begin
            // Halted, restart from word 0
            pc         <= '0;
            fetchValid <= 1'b0;
        end else begin
            pc         <= nextPc;
            fetchValid <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory and fetch register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemWdata;
        end
        // Word at PC lands here one cycle later
        if (run) begin
            fetchInstr <= imem[pc];
            fetchPc    <= pc;
        end
    end

    // Program is only loaded while the core is halted
    assert property (@(posedge clk) disable iff (!rstN) !(imemWe && run))
        else $error("imem written while running");

endmodule

// File: rtl/Controller.sv
`timescale 1ns/1ns

module Controller (
    input  mipsPkg::word_t instruction,
    input  logic           branchDiffer,
    input  logic           controlEnable,
    output mipsPkg::ctrl_t ctrl
);
    import mipsPkg::*;

    // Funct codes for the R-type ops in use
    localparam logic [5:0] functAdd = 6'b100000;
    localparam logic [5:0] functSub = 6'b100010;
    localparam logic [5:0] functSlt = 6'b101010;

    opcode_t    opcode;
    logic [5:0] funct;

    assign opcode = opcode_t'(instruction[31:26]);
    assign funct  = instruction[5:0];

    ////////////////////////////////////////////////////////////
    // Decode table
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Bubble by default
        ctrl            = '0;
        ctrl.aluControl = AluNone;

        if (!controlEnable) begin
            // Squashed or empty slot, everything inactive
            ctrl.aluControl = AluOff;
        end else begin
            case (opcode)
                OpRtype: begin
                    case (funct)
                        functAdd: ctrl.aluControl = AluAdd;
                        functSub: ctrl.aluControl = AluSub;
                        functSlt: ctrl.aluControl = AluSlt;
                        default:  ctrl.aluControl = AluNone;
                    endcase
                    // Unsupported funct stays a bubble
                    ctrl.regWrite = (ctrl.aluControl != AluNone);
                    ctrl.regDst   = ctrl.regWrite;
                end
                OpMul: begin
                    // Special2 encoding, rd destination
                    ctrl.regWrite   = 1'b1;
                    ctrl.regDst     = 1'b1;
                    ctrl.aluControl = AluMul;
                end
                OpLw: begin
                    // Address is base plus offset
                    ctrl.regWrite   = 1'b1;
                    ctrl.aluSrc     = 1'b1;
                    ctrl.memRead    = 1'b1;
                    ctrl.memToReg   = 1'b1;
                    ctrl.aluControl = AluAdd;
                end
                OpAddi: begin
                    ctrl.regWrite   = 1'b1;
                    ctrl.aluSrc     = 1'b1;
                    ctrl.aluControl = AluAdd;
                end
                OpOri: begin
                    // Immediate is zero-extended in the datapath
                    ctrl.regWrite   = 1'b1;
                    ctrl.aluSrc     = 1'b1;
                    ctrl.aluControl = AluOr;
                end
                OpBne: begin
                    // Taken only when the comparator sees a difference
                    ctrl.pcSrc = branchDiffer;
                end
                OpJ: begin
                    ctrl.jump = 1'b1;
                end
                default: begin
                    ctrl.aluControl = AluNone;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    always_comb begin
        // At most one redirect source
        assert final (!(ctrl.pcSrc && ctrl.jump))
            else $error("pcSrc and jump both high");
        assert final (!ctrl.pcSrc || opcode == OpBne)
            else $error("pcSrc high for opcode %b", instruction[31:26]);
        // Disabled slot must not leak any control
        assert final (controlEnable || ctrl == '0)
            else $error("ctrl active while disabled");
    end

endmodule

// File: rtl/mipsPkg.sv
`include "mips_settings.svh"

package mipsPkg;

    ////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////

    // One data or instruction word
    typedef logic [`MIPS_WORD_W-1:0] word_t;

    // Register index
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] regAddr_t;

    // Word indices into the two memories
    typedef logic [$clog2(`MIPS_IMEM_DEPTH)-1:0] imemAddr_t;
    typedef logic [$clog2(`MIPS_DMEM_DEPTH)-1:0] dmemAddr_t;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Opcodes the core executes
    // Anything else decodes as a bubble
    typedef enum logic [5:0] {
        OpRtype = 6'b000000,
        OpJ     = 6'b000010,
        OpBne   = 6'b000101,
        OpAddi  = 6'b001000,
        OpOri   = 6'b001101,
        OpMul   = 6'b011100,
        OpLw    = 6'b100011
    } opcode_t;

    // ALU select codes
    typedef enum logic [4:0] {
        AluOff  = 5'd0,
        AluAdd  = 5'd1,
        AluSub  = 5'd2,
        AluMul  = 5'd3,
        AluOr   = 5'd7,
        AluSlt  = 5'd14,
        AluNone = `MIPS_ALU_NONE
    } aluCtrl_t;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    // Decoder outputs in 12 bits
    typedef struct packed {
        logic     regWrite;
        logic     aluSrc;
        logic     regDst;
        logic     memRead;
        // 1 selects the loaded word for write-back
        logic     memToReg;
        logic     jump;
        logic     pcSrc;
        aluCtrl_t aluControl;
    } ctrl_t;

    // One register write-back as seen by the host
    typedef struct packed {
        logic     valid;
        regAddr_t rd;
        word_t    data;
    } retire_t;

endpackage

// File: rtl/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Datapath and instruction width
`define MIPS_WORD_W 32

// Architectural register count, index width follows from it
`define MIPS_REG_COUNT 32

// Memory depths in words
`define MIPS_IMEM_DEPTH 64
`define MIPS_DMEM_DEPTH 64

// ALU code for an enabled slot that does no arithmetic
// A squashed slot drives zero instead
`define MIPS_ALU_NONE 5'b11111

`endif
